//--- logic/mipsCtrlPkg.sv
package mipsCtrlPkg;

	// control bus widths
	localparam int phaseW = 3;
	localparam int classW = 4;
	localparam int pcSelW = 3;
	localparam int aluOpW = 3;
	localparam int aluSrcBW = 3;
	localparam int regSrcW = 3;
	localparam int regDestW = 2;
	localparam int brCondW = 3;

	// instruction register, seen in register or immediate format
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rView;
		struct packed {
			logic [5:0] opcode;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [15:0] imm;
		} iView;
	} instrWord;

	localparam logic [5:0] opRType = 6'b000000;	// all r-type share this
	localparam logic [5:0] opBltz = 6'b000001;
	localparam logic [5:0] opJ = 6'b000010;
	localparam logic [5:0] opJal = 6'b000011;
	localparam logic [5:0] opBeq = 6'b000100;
	localparam logic [5:0] opBne = 6'b000101;
	localparam logic [5:0] opBlez = 6'b000110;
	localparam logic [5:0] opBgtz = 6'b000111;
	localparam logic [5:0] opAddi = 6'b001000;	// signed, may overflow
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi = 6'b001100;
	localparam logic [5:0] opOri = 6'b001101;
	localparam logic [5:0] opXori = 6'b001110;
	localparam logic [5:0] opMfc0 = 6'b010000;	// move from coprocessor 0
	localparam logic [5:0] opLw = 6'b100011;
	localparam logic [5:0] opSw = 6'b101011;

	localparam logic [5:0] fnJr = 6'b001000;
	localparam logic [5:0] fnJalr = 6'b001001;
	localparam logic [5:0] fnAdd = 6'b100000;	// signed add, traps on overflow
	localparam logic [5:0] fnSub = 6'b100010;	// signed sub, traps on overflow

	// funct codes the ALU accepts
	localparam int aluFunctCount = 16;
	localparam logic [aluFunctCount-1:0][5:0] aluFuncts = {
		6'b100000, 6'b100001, 6'b100010, 6'b100011,
		6'b100100, 6'b100101, 6'b100110, 6'b100111,
		6'b000000, 6'b000100, 6'b000010, 6'b000110,
		6'b000011, 6'b000111, 6'b101001, 6'b101010
	};

	localparam logic [phaseW-1:0] phFetch = 3'd0;
	localparam logic [phaseW-1:0] phDecode = 3'd1;
	localparam logic [phaseW-1:0] phExecute = 3'd2;
	localparam logic [phaseW-1:0] phMemory = 3'd3;	// also register write for most
	localparam logic [phaseW-1:0] phWriteback = 3'd4;	// load and store only

	localparam logic [classW-1:0] clAluR = 4'd0;
	localparam logic [classW-1:0] clJr = 4'd1;
	localparam logic [classW-1:0] clJalr = 4'd2;
	localparam logic [classW-1:0] clJ = 4'd3;
	localparam logic [classW-1:0] clJal = 4'd4;
	localparam logic [classW-1:0] clBranch = 4'd5;
	localparam logic [classW-1:0] clAluImm = 4'd6;	// immediate ops that never trap
	localparam logic [classW-1:0] clAddi = 4'd7;
	localparam logic [classW-1:0] clLoad = 4'd8;
	localparam logic [classW-1:0] clStore = 4'd9;
	localparam logic [classW-1:0] clMfcEpc = 4'd10;
	localparam logic [classW-1:0] clMfcCause = 4'd11;
	localparam logic [classW-1:0] clInvalid = 4'd12;

	localparam logic [pcSelW-1:0] pcIncr = 3'd0;
	localparam logic [pcSelW-1:0] pcBranch = 3'd1;
	localparam logic [pcSelW-1:0] pcJump = 3'd2;	// pc upper bits and 26-bit target
	localparam logic [pcSelW-1:0] pcReg = 3'd3;	// rs contents
	localparam logic [pcSelW-1:0] pcTrap = 3'd4;

	localparam logic [aluSrcBW-1:0] srcReg = 3'd0;
	localparam logic [aluSrcBW-1:0] srcOne = 3'd1;
	localparam logic [aluSrcBW-1:0] srcImm = 3'd2;
	localparam logic [aluSrcBW-1:0] srcBrOff = 3'd3;	// extended offset shifted by 2
	localparam logic [aluSrcBW-1:0] srcZero = 3'd4;

	localparam logic [aluOpW-1:0] aluAdd = 3'd0;
	localparam logic [aluOpW-1:0] aluSub = 3'd1;
	localparam logic [aluOpW-1:0] aluFunct = 3'd2;	// ALU decodes funct itself
	localparam logic [aluOpW-1:0] aluSlt = 3'd3;
	localparam logic [aluOpW-1:0] aluAnd = 3'd4;
	localparam logic [aluOpW-1:0] aluOr = 3'd5;
	localparam logic [aluOpW-1:0] aluXor = 3'd6;

	localparam logic [regSrcW-1:0] fromAlu = 3'd0;
	localparam logic [regSrcW-1:0] fromEpc = 3'd2;
	localparam logic [regSrcW-1:0] fromCause = 3'd3;
	localparam logic [regSrcW-1:0] fromMem = 3'd4;
	localparam logic [regSrcW-1:0] fromLink = 3'd5;	// return address

	localparam logic [regDestW-1:0] destRt = 2'd0;
	localparam logic [regDestW-1:0] destRd = 2'd1;
	localparam logic [regDestW-1:0] destRa = 2'd2;	// r31 for jal

	localparam logic [brCondW-1:0] brNone = 3'd0;
	localparam logic [brCondW-1:0] brEq = 3'd1;
	localparam logic [brCondW-1:0] brNe = 3'd2;
	localparam logic [brCondW-1:0] brGtz = 3'd3;
	localparam logic [brCondW-1:0] brLtz = 3'd4;
	localparam logic [brCondW-1:0] brLez = 3'd5;

	localparam logic causeOverflow = 1'b0;
	localparam logic causeInvalid = 1'b1;

endpackage

//--- logic/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder #(
	parameter int epcRegNum = 14,	// cp0 register read as EPC
	parameter int causeRegNum = 13	// cp0 register read as Cause
) (
	input mipsCtrlPkg::instrWord instr,
	output logic [mipsCtrlPkg::classW-1:0] instrClass,
	output logic [mipsCtrlPkg::aluOpW-1:0] aluImmOp,
	output logic zeroExt,
	output logic [mipsCtrlPkg::brCondW-1:0] branchCond
);

	import mipsCtrlPkg::*;

	logic functLegal;	// funct is one the ALU implements

	always_comb begin
		functLegal = 1'b0;
		for (int i = 0; i < aluFunctCount; i++) begin
			if (instr.rView.funct == aluFuncts[i])
				functLegal = 1'b1;
		end
	end

	always_comb begin
		instrClass = clInvalid;	// anything unmatched traps
		aluImmOp = aluAdd;
		zeroExt = 1'b0;
		branchCond = brNone;
		case (instr.iView.opcode)
			opRType: begin
				if (instr.rView.funct == fnJr)
					instrClass = clJr;
				else if (instr.rView.funct == fnJalr)
					instrClass = clJalr;
				else if (functLegal)
					instrClass = clAluR;
			end
			opJ: instrClass = clJ;
			opJal: instrClass = clJal;
			opMfc0: begin
				// only two cp0 registers are readable
				if (instr.rView.rd == 5'(epcRegNum))
					instrClass = clMfcEpc;
				else if (instr.rView.rd == 5'(causeRegNum))
					instrClass = clMfcCause;
			end
			opBeq: begin
				instrClass = clBranch;
				branchCond = brEq;
			end
			opBne: begin
				instrClass = clBranch;
				branchCond = brNe;
			end
			opBgtz: begin
				instrClass = clBranch;
				branchCond = brGtz;
			end
			opBltz: begin
				instrClass = clBranch;
				branchCond = brLtz;
			end
			opBlez: begin
				instrClass = clBranch;
				branchCond = brLez;
			end
			opAddi: instrClass = clAddi;	// separate class for the overflow check
			opAddiu: begin
				instrClass = clAluImm;
				zeroExt = 1'b1;	// immediate zero extended
			end
			opSlti: begin
				instrClass = clAluImm;
				aluImmOp = aluSlt;
			end
			opSltiu: begin
				instrClass = clAluImm;
				aluImmOp = aluSlt;
				zeroExt = 1'b1;
			end
			opAndi: begin
				instrClass = clAluImm;
				aluImmOp = aluAnd;
			end
			opOri: begin
				instrClass = clAluImm;
				aluImmOp = aluOr;
			end
			opXori: begin
				instrClass = clAluImm;
				aluImmOp = aluXor;
			end
			opLw: instrClass = clLoad;
			opSw: instrClass = clStore;
			default: ;
		endcase
	end

endmodule

//--- logic/trapDetect.sv
`timescale 1ns/100ps

module trapDetect (
	input logic [mipsCtrlPkg::phaseW-1:0] phase,
	input logic [mipsCtrlPkg::classW-1:0] instrClass,
	input mipsCtrlPkg::instrWord instr,
	input logic overflow,	// from ALU, valid in memory phase
	input logic badFunct,	// ALU rejected the funct
	output logic trap,
	output logic trapCause
);

	import mipsCtrlPkg::*;

	logic signedArith;	// add or sub that must not overflow

	assign signedArith = (instr.rView.funct == fnAdd) || (instr.rView.funct == fnSub);

	always_comb begin
		trap = 1'b0;
		trapCause = causeOverflow;
		case (phase)
			phExecute: begin
				if (instrClass == clInvalid) begin	// unknown opcode, funct or cp0 reg
					trap = 1'b1;
					trapCause = causeInvalid;
				end
			end
			phMemory: begin
				if (instrClass == clAluR) begin
					if (badFunct) begin	// takes priority over overflow
						trap = 1'b1;
						trapCause = causeInvalid;
					end else if (overflow && signedArith) begin
						trap = 1'b1;
					end
				end else if (instrClass == clAddi && overflow) begin
					trap = 1'b1;
				end
			end
			default: ;
		endcase
	end

endmodule

//--- logic/phaseSequencer.sv
`timescale 1ns/100ps

module phaseSequencer (
	input logic clk,
	input logic rst,
	input logic [mipsCtrlPkg::classW-1:0] instrClass,
	input logic trap,
	output logic [mipsCtrlPkg::phaseW-1:0] phase
);

	import mipsCtrlPkg::*;

	logic [phaseW-1:0] nextPhase;
	logic endsInExecute;	// no register write needed

	assign endsInExecute = (instrClass == clJ) || (instrClass == clJr)
		|| (instrClass == clBranch);

	always_comb begin
		case (phase)
			phFetch: nextPhase = phDecode;
			phDecode: nextPhase = phExecute;
			phExecute: begin
				if (trap || endsInExecute)
					nextPhase = phFetch;
				else
					nextPhase = phMemory;
			end
			phMemory: begin
				// only memory accesses need the extra phase
				if (!trap && (instrClass == clLoad || instrClass == clStore))
					nextPhase = phWriteback;
				else
					nextPhase = phFetch;
			end
			default: nextPhase = phFetch;	// writeback and unused codes
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			phase <= phFetch;
		else
			phase <= nextPhase;
	end

	// phase never leaves the five codes
	assert property (@(posedge clk) disable iff (rst) phase <= phWriteback);

	assert property (@(posedge clk) disable iff (rst)
		phase == phWriteback |-> $past(phase) == phMemory);

	// traps only come from execute or memory checks
	assert property (@(posedge clk) disable iff (rst)
		trap |-> (phase == phExecute || phase == phMemory));

endmodule

//--- logic/datapathCtrl.sv
`timescale 1ns/100ps

module datapathCtrl (
	input logic rst,
	input logic [mipsCtrlPkg::phaseW-1:0] phase,
	input logic [mipsCtrlPkg::classW-1:0] instrClass,
	input logic [mipsCtrlPkg::aluOpW-1:0] aluImmOp,
	input logic zeroExt,
	input logic [mipsCtrlPkg::brCondW-1:0] branchCond,
	input logic trap,
	input logic trapCause,
	output logic pcEn,
	output logic [mipsCtrlPkg::pcSelW-1:0] pcSel,
	output logic iOrD,	// 0 pc, 1 ALU result as memory address
	output logic memRead,
	output logic memWrite,
	output logic irEn,
	output logic regRead,
	output logic regWrite,
	output logic [mipsCtrlPkg::regDestW-1:0] regDest,
	output logic [mipsCtrlPkg::regSrcW-1:0] regSrc,
	output logic signZero,	// 1 zero extends the immediate
	output logic aluSrcA,	// 0 pc, 1 rs
	output logic [mipsCtrlPkg::aluSrcBW-1:0] aluSrcB,
	output logic [mipsCtrlPkg::aluOpW-1:0] aluOp,
	output logic [mipsCtrlPkg::brCondW-1:0] brCondOut,
	output logic epcEn,
	output logic causeEn,
	output logic causeSel
);

	import mipsCtrlPkg::*;

	logic [regDestW-1:0] classDest;	// write target for the class
	logic [regSrcW-1:0] classSrc;

	always_comb begin
		classDest = destRt;
		classSrc = fromAlu;
		case (instrClass)
			clAluR: classDest = destRd;
			clJalr: begin
				classDest = destRd;
				classSrc = fromLink;
			end
			clJal: begin
				classDest = destRa;
				classSrc = fromLink;
			end
			clMfcEpc: begin
				classDest = destRd;
				classSrc = fromEpc;
			end
			clMfcCause: begin
				classDest = destRd;
				classSrc = fromCause;
			end
			clLoad: classSrc = fromMem;
			default: ;
		endcase
	end

	always_comb begin
		pcEn = 1'b0;
		pcSel = pcIncr;
		iOrD = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		irEn = 1'b0;
		regRead = 1'b0;
		regWrite = 1'b0;
		regDest = destRt;
		regSrc = fromAlu;
		signZero = 1'b0;
		aluSrcA = 1'b0;
		aluSrcB = srcReg;
		aluOp = aluAdd;
		brCondOut = brNone;
		epcEn = 1'b0;
		causeEn = 1'b0;
		causeSel = causeOverflow;
		if (trap) begin	// save pc and cause, vector away
			epcEn = 1'b1;
			causeEn = 1'b1;
			causeSel = trapCause;
			pcSel = pcTrap;
		end else begin
			case (phase)
				phFetch: begin
					memRead = 1'b1;	// instruction at pc
					irEn = 1'b1;
					regRead = 1'b1;
					aluSrcB = srcOne;	// pc plus one
					pcEn = 1'b1;
				end
				phDecode: aluSrcB = srcBrOff;	// precompute branch target
				phExecute: begin
					regDest = classDest;
					regSrc = classSrc;
					case (instrClass)
						clAluR: begin
							aluSrcA = 1'b1;
							aluOp = aluFunct;
						end
						clAluImm: begin
							aluSrcA = 1'b1;
							aluSrcB = srcImm;
							aluOp = aluImmOp;
							signZero = zeroExt;
						end
						clAddi, clLoad, clStore: begin	// rs plus signed immediate
							aluSrcA = 1'b1;
							aluSrcB = srcImm;
						end
						clBranch: begin
							aluSrcA = 1'b1;
							// beq and bne compare rs with rt, the rest with zero
							if (branchCond != brEq && branchCond != brNe)
								aluSrcB = srcZero;
							aluOp = aluSub;
							pcSel = pcBranch;
							brCondOut = branchCond;	// datapath gates the pc load
						end
						clJr: begin
							pcSel = pcReg;
							pcEn = 1'b1;
						end
						clJ: begin
							pcSel = pcJump;
							pcEn = 1'b1;
						end
						default: ;
					endcase
				end
				phMemory: begin
					regDest = classDest;
					regSrc = classSrc;
					case (instrClass)
						clAluR, clAluImm, clAddi, clMfcEpc, clMfcCause: regWrite = 1'b1;
						clJalr: begin	// link then jump
							pcSel = pcReg;
							pcEn = 1'b1;
							regWrite = 1'b1;
						end
						clJal: begin
							pcSel = pcJump;
							pcEn = 1'b1;
							regWrite = 1'b1;
						end
						clLoad: begin
							iOrD = 1'b1;
							memRead = 1'b1;
						end
						clStore: iOrD = 1'b1;	// address settles a cycle early
						default: ;
					endcase
				end
				phWriteback: begin
					if (instrClass == clStore) begin
						iOrD = 1'b1;
						memWrite = 1'b1;
					end else if (instrClass == clLoad) begin
						regDest = classDest;
						regSrc = classSrc;
						regWrite = 1'b1;	// loaded word into rt
					end
				end
				default: ;
			endcase
		end
		if (rst) begin	// no state changes while in reset
			pcEn = 1'b0;
			memRead = 1'b0;
			memWrite = 1'b0;
			irEn = 1'b0;
			regRead = 1'b0;
			regWrite = 1'b0;
			epcEn = 1'b0;
			causeEn = 1'b0;
		end
	end

endmodule

//--- logic/mipsControl.sv
`timescale 1ns/100ps

module mipsControl #(
	parameter int epcRegNum = 14,
	parameter int causeRegNum = 13
) (
	input logic clk,
	input logic rst,
	input mipsCtrlPkg::instrWord instr,	// held from decode to end of instruction
	input logic overflow,
	input logic badFunct,
	output logic pcEn,
	output logic [mipsCtrlPkg::pcSelW-1:0] pcSel,
	output logic iOrD,
	output logic memRead,
	output logic memWrite,
	output logic irEn,
	output logic regRead,
	output logic regWrite,
	output logic [mipsCtrlPkg::regDestW-1:0] regDest,
	output logic [mipsCtrlPkg::regSrcW-1:0] regSrc,
	output logic signZero,
	output logic aluSrcA,
	output logic [mipsCtrlPkg::aluSrcBW-1:0] aluSrcB,
	output logic [mipsCtrlPkg::aluOpW-1:0] aluOp,
	output logic [mipsCtrlPkg::brCondW-1:0] brCondOut,
	output logic epcEn,
	output logic causeEn,
	output logic causeSel
);

	import mipsCtrlPkg::*;

	logic [classW-1:0] instrClass;
	logic [aluOpW-1:0] aluImmOp;
	logic zeroExt;
	logic [brCondW-1:0] branchCond;
	logic [phaseW-1:0] phase;
	logic trap;
	logic trapCause;

	instrDecoder #(
		.epcRegNum(epcRegNum),
		.causeRegNum(causeRegNum)
	) instrDecoder_inst (
		.instr(instr),
		.instrClass(instrClass),
		.aluImmOp(aluImmOp),
		.zeroExt(zeroExt),
		.branchCond(branchCond)
	);

	trapDetect trapDetect_inst (
		.phase(phase),
		.instrClass(instrClass),
		.instr(instr),
		.overflow(overflow),
		.badFunct(badFunct),
		.trap(trap),
		.trapCause(trapCause)
	);

	phaseSequencer phaseSequencer_inst (
		.clk(clk),
		.rst(rst),
		.instrClass(instrClass),
		.trap(trap),
		.phase(phase)
	);

	datapathCtrl datapathCtrl_inst (
		.rst(rst),
		.phase(phase),
		.instrClass(instrClass),
		.aluImmOp(aluImmOp),
		.zeroExt(zeroExt),
		.branchCond(branchCond),
		.trap(trap),
		.trapCause(trapCause),
		.pcEn(pcEn),
		.pcSel(pcSel),
		.iOrD(iOrD),
		.memRead(memRead),
		.memWrite(memWrite),
		.irEn(irEn),
		.regRead(regRead),
		.regWrite(regWrite),
		.regDest(regDest),
		.regSrc(regSrc),
		.signZero(signZero),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.brCondOut(brCondOut),
		.epcEn(epcEn),
		.causeEn(causeEn),
		.causeSel(causeSel)
	);

	// single memory port, never read and written together
	assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite));

	// a branch loads pc only through the condition path
	assert property (@(posedge clk) disable iff (rst) !(pcEn && brCondOut != brNone));

endmodule

//--- test/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
	parameter int halfPeriod = 50,	// 100 ns clock
	parameter int resetCycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#10 rst = 1'b0;	// drops off the edge, same as the other inputs
	end

endmodule

//--- test/controlTb.sv
`timescale 1ns/100ps

module controlTb;

	import mipsCtrlPkg::*;

	localparam int goldenDepth = 512;	// 9-bit row address
	localparam int fieldsPerLine = 5;	// instr, overflow, badFunct, enables, selects
	localparam int maxLines = goldenDepth / fieldsPerLine;
	localparam logic [47:0] endMark = 48'hf;	// overflow column of the closing line

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic overflow;
	logic badFunct;
	logic pcEn;
	logic [pcSelW-1:0] pcSel;
	logic iOrD;
	logic memRead;
	logic memWrite;
	logic irEn;
	logic regRead;
	logic regWrite;
	logic [regDestW-1:0] regDest;
	logic [regSrcW-1:0] regSrc;
	logic signZero;
	logic aluSrcA;
	logic [aluSrcBW-1:0] aluSrcB;
	logic [aluOpW-1:0] aluOp;
	logic [brCondW-1:0] brCondOut;
	logic epcEn;
	logic causeEn;
	logic causeSel;

	logic [47:0] golden [goldenDepth];	// five words per cycle
	int lineCount;
	int lineIdx;	// cycle under test, shown in error lines
	int cycleLimit;
	int cycleCount = 0;

	clockGen clockGen_inst (
		.clk(clk),
		.rst(rst)
	);

	mipsControl #(
		.epcRegNum(14),
		.causeRegNum(13)
	) mipsControl_inst (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.overflow(overflow),
		.badFunct(badFunct),
		.pcEn(pcEn),
		.pcSel(pcSel),
		.iOrD(iOrD),
		.memRead(memRead),
		.memWrite(memWrite),
		.irEn(irEn),
		.regRead(regRead),
		.regWrite(regWrite),
		.regDest(regDest),
		.regSrc(regSrc),
		.signZero(signZero),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.brCondOut(brCondOut),
		.epcEn(epcEn),
		.causeEn(causeEn),
		.causeSel(causeSel)
	);

	function automatic logic [8:0] rowBase(input int row);
		return 9'(row * fieldsPerLine);	// first word of a golden line
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("[FAIL] cycle %0d %s expected 0x%0h got 0x%0h", lineIdx, name,
				expected, actual);
			$display("tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// fetch phase under reset, every enable held low
	task automatic checkResetEnables;
		checkValue("pcEn", 32'd0, 32'(pcEn));
		checkValue("memRead", 32'd0, 32'(memRead));
		checkValue("memWrite", 32'd0, 32'(memWrite));
		checkValue("irEn", 32'd0, 32'(irEn));
		checkValue("regRead", 32'd0, 32'(regRead));
		checkValue("regWrite", 32'd0, 32'(regWrite));
		checkValue("epcEn", 32'd0, 32'(epcEn));
		checkValue("causeEn", 32'd0, 32'(causeEn));
	endtask

	task automatic applyInputs(input int row);
		logic [8:0] base;
		base = rowBase(row);
		instr = golden[base][31:0];
		overflow = golden[base + 9'd1][0];
		badFunct = golden[base + 9'd2][0];
	endtask

	task automatic compareCycle(input int row);
		logic [8:0] base;
		logic [47:0] en;
		logic [47:0] sel;
		base = rowBase(row);
		en = golden[base + 9'd3];	// one hex digit per enable
		sel = golden[base + 9'd4];	// one hex digit per select
		checkValue("pcEn", 32'(en[47:44]), 32'(pcEn));
		checkValue("iOrD", 32'(en[43:40]), 32'(iOrD));
		checkValue("memRead", 32'(en[39:36]), 32'(memRead));
		checkValue("memWrite", 32'(en[35:32]), 32'(memWrite));
		checkValue("irEn", 32'(en[31:28]), 32'(irEn));
		checkValue("regRead", 32'(en[27:24]), 32'(regRead));
		checkValue("regWrite", 32'(en[23:20]), 32'(regWrite));
		checkValue("signZero", 32'(en[19:16]), 32'(signZero));
		checkValue("aluSrcA", 32'(en[15:12]), 32'(aluSrcA));
		checkValue("epcEn", 32'(en[11:8]), 32'(epcEn));
		checkValue("causeEn", 32'(en[7:4]), 32'(causeEn));
		checkValue("causeSel", 32'(en[3:0]), 32'(causeSel));
		checkValue("pcSel", 32'(sel[23:20]), 32'(pcSel));
		checkValue("regDest", 32'(sel[19:16]), 32'(regDest));
		checkValue("regSrc", 32'(sel[15:12]), 32'(regSrc));
		checkValue("aluSrcB", 32'(sel[11:8]), 32'(aluSrcB));
		checkValue("aluOp", 32'(sel[7:4]), 32'(aluOp));
		checkValue("brCondOut", 32'(sel[3:0]), 32'(brCondOut));
	endtask

	// run limit grows with the golden file
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	initial begin
		void'($urandom(88168));	// fixed seed, stimulus itself is all from the file
		instr = '0;
		overflow = 1'b0;
		badFunct = 1'b0;
		cycleLimit = 0;
		$readmemh("test/controlGolden.mem", golden);
		lineCount = 0;
		while (lineCount < maxLines && golden[rowBase(lineCount) + 9'd1] != endMark)
			lineCount++;
		if (lineCount == maxLines) begin
			$display("golden file has no end line or holds too many cycles");
			$display("tests failed");
			$fatal(1, "bad golden file");
		end
		cycleLimit = lineCount + 20;	// reset and slack on top of one cycle per line
		@(posedge clk);	// phase now held at fetch
		#80;
		checkResetEnables();
		@(negedge rst);	// 10 ns after the last reset edge
		for (lineIdx = 0; lineIdx < lineCount; lineIdx++) begin
			applyInputs(lineIdx);
			#80;	// just before the next rising edge
			compareCycle(lineIdx);
			@(posedge clk);
			#10;
		end
		$display("all tests passed");
		$finish;
	end

endmodule

//--- test/controlGolden.mem
// columns: instr, overflow, badFunct, enables, selects, all hex, one line per cycle
// enables, a digit each: pcEn iOrD memRead memWrite irEn regRead regWrite signZero
//   aluSrcA epcEn causeEn causeSel
// selects, a digit each: pcSel regDest regSrc aluSrcB aluOp brCondOut; overflow f ends
00222821 0 0 101011000000 000100 // addu r5 with overflow, no trap
00222821 0 0 000000000000 000300
00222821 1 0 000000001000 010020
00222821 1 0 000000100000 010000
03E00008 0 0 101011000000 000100 // jr r31
03E00008 0 0 000000000000 000300
03E00008 0 0 100000000000 300000
00A0F809 0 0 101011000000 000100 // jalr r31, r5
00A0F809 0 0 000000000000 000300
00A0F809 0 0 000000000000 015000
00A0F809 0 0 100000100000 315000
08000010 0 0 101011000000 000100 // j
08000010 0 0 000000000000 000300
08000010 0 0 100000000000 200000
0C000020 0 0 101011000000 000100 // jal
0C000020 0 0 000000000000 000300
0C000020 0 0 000000000000 025000
0C000020 0 0 100000100000 225000
10220004 0 0 101011000000 000100 // beq
10220004 0 0 000000000000 000300
10220004 0 0 000000001000 100011
14220004 0 0 101011000000 000100 // bne
14220004 0 0 000000000000 000300
14220004 0 0 000000001000 100012
1C200003 0 0 101011000000 000100 // bgtz
1C200003 0 0 000000000000 000300
1C200003 0 0 000000001000 100413
04200003 0 0 101011000000 000100 // bltz
04200003 0 0 000000000000 000300
04200003 0 0 000000001000 100414
18200003 0 0 101011000000 000100 // blez
18200003 0 0 000000000000 000300
18200003 0 0 000000001000 100415
20220005 0 0 101011000000 000100 // addi
20220005 0 0 000000000000 000300
20220005 0 0 000000001000 000200
20220005 0 0 000000100000 000000
2C220005 0 0 101011000000 000100 // sltiu, zero extended
2C220005 0 0 000000000000 000300
2C220005 0 0 000000011000 000230
2C220005 0 0 000000100000 000000
38220005 0 0 101011000000 000100 // xori
38220005 0 0 000000000000 000300
38220005 0 0 000000001000 000260
38220005 0 0 000000100000 000000
8C220008 0 0 101011000000 000100 // lw
8C220008 0 0 000000000000 000300
8C220008 0 0 000000001000 004200
8C220008 0 0 011000000000 004000
8C220008 0 0 000000100000 004000
AC220008 0 0 101011000000 000100 // sw
AC220008 0 0 000000000000 000300
AC220008 0 0 000000001000 000200
AC220008 0 0 010000000000 000000
AC220008 0 0 010100000000 000000
40027000 0 0 101011000000 000100 // mfc0 epc
40027000 0 0 000000000000 000300
40027000 0 0 000000000000 012000
40027000 0 0 000000100000 012000
40026800 0 0 101011000000 000100 // mfc0 cause
40026800 0 0 000000000000 000300
40026800 0 0 000000000000 013000
40026800 0 0 000000100000 013000
40026000 0 0 101011000000 000100 // mfc0 rd 12 traps
40026000 0 0 000000000000 000300
40026000 0 0 000000000111 400000
FC000000 0 0 101011000000 000100 // unknown opcode
FC000000 0 0 000000000000 000300
FC000000 0 0 000000000111 400000
00221801 0 0 101011000000 000100 // funct 01 not in the alu list
00221801 0 0 000000000000 000300
00221801 0 0 000000000111 400000
00222022 0 0 101011000000 000100 // sub overflow
00222022 0 0 000000000000 000300
00222022 0 0 000000001000 010020
00222022 1 0 000000000110 400000
20220005 0 0 101011000000 000100 // addi overflow
20220005 0 0 000000000000 000300
20220005 0 0 000000001000 000200
20220005 1 0 000000000110 400000
00221820 0 0 101011000000 000100 // add, bad funct wins over overflow
00221820 0 0 000000000000 000300
00221820 0 0 000000001000 010020
00221820 1 1 000000000111 400000
00000000 f f 000000000000 000000

//--- sources.f
logic/mipsCtrlPkg.sv
logic/instrDecoder.sv
logic/trapDetect.sv
logic/phaseSequencer.sv
logic/datapathCtrl.sv
logic/mipsControl.sv
test/clockGen.sv
test/controlTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# builds the control unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module controlTb \
	-f sources.f \
	-o controlSim

# the log decides the result, a fatal stop leaves no pass line
./obj_dir/controlSim | tee sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation PASSED"
else
	echo "simulation FAILED"
	exit 1
fi
